//--- vlog.f
verilog/gt_reg_pkg.sv
verilog/touch_ctrl_pkg.sv
verilog/tp_power_seq.sv
verilog/touch_seq_fsm.sv
verilog/tp_coord_assembler.sv
verilog/tp_coord_store.sv
verilog/touch_ctrl_top.sv
tb/tb_clk_gen.sv
tb/gt_touch_model.sv
tb/tb_touch_ctrl.sv

//--- tb/tb_touch_ctrl.sv
// touch controller testbench
// power-up timing, config writes with nack retry, status polls and point reads

`timescale 1ns/1ps

module tb_touch_ctrl;
    import gt_reg_pkg::*;
    import touch_ctrl_pkg::*;

    logic       clk;
    logic       rst_n;
    wire        tft_int;
    logic       tft_tcs;
    logic       ack;
    logic       i2c_done;
    logic       once_done;
    reg_data_t  i2c_data_r;
    logic       i2c_exec;
    logic       i2c_rh_wl;
    reg_addr_t  i2c_addr;
    reg_data_t  i2c_data_w;
    burst_len_t reg_num;
    tp_count_t  tp_num;
    point_xy_t  tp1_xy, tp2_xy, tp3_xy, tp4_xy, tp5_xy;
    logic       touch_valid;

    integer     seed;
    int         err_cnt;
    int         test_cnt;
    int         test_fail;
    tp_count_t  exp_num;
    logic       exp_valid;
    point_xy_t  exp_slot [MAX_POINTS];

    tb_clk_gen #(.PERIOD(8.0), .RESET_CYCLES(5)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    touch_ctrl_top u_touch_ctrl_top (
        .clk(clk), .rst_n(rst_n), .tft_tcs(tft_tcs), .tft_int(tft_int),
        .ack(ack), .i2c_done(i2c_done), .once_done(once_done), .i2c_data_r(i2c_data_r),
        .i2c_exec(i2c_exec), .i2c_rh_wl(i2c_rh_wl), .i2c_addr(i2c_addr),
        .i2c_data_w(i2c_data_w), .reg_num(reg_num), .tp_num(tp_num),
        .tp1_xy(tp1_xy), .tp2_xy(tp2_xy), .tp3_xy(tp3_xy), .tp4_xy(tp4_xy),
        .tp5_xy(tp5_xy), .touch_valid(touch_valid)
    );

    gt_touch_model #(.SEED(32'h637c_db36)) u_model (
        .clk(clk), .rst_n(rst_n), .i2c_exec(i2c_exec), .i2c_rh_wl(i2c_rh_wl),
        .i2c_addr(i2c_addr), .i2c_data_w(i2c_data_w), .reg_num(reg_num),
        .ack(ack), .i2c_done(i2c_done), .once_done(once_done), .i2c_data_r(i2c_data_r)
    );

    // --------------------
    // expected {valid, count} for a status byte
    function automatic logic [3:0] decode_status(input reg_data_t st);
        logic ok;
        ok = st[7] && (st[3:0] >= 4'd1) && (st[3:0] <= 4'd5);
        return ok ? {1'b1, st[2:0]} : 4'b0000;
    endfunction

    function automatic point_xy_t pack_pair(input reg_data_t xl, xh, yl, yh);
        return {xh, xl, yh, yl};
    endfunction

    function automatic point_xy_t slot_out(input int i);
        case (i)
            0: return tp1_xy;
            1: return tp2_xy;
            2: return tp3_xy;
            3: return tp4_xy;
            default: return tp5_xy;
        endcase
    endfunction

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic wait_log(input int n, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (u_model.log_cnt < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                abort_run(what);
        end
    endtask

    task automatic check_value(input logic ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            err_cnt++;
        end
    endtask

    task automatic compare_trans(input int idx, input reg_addr_t a, input logic rd,
                                 input reg_data_t wd, input burst_len_t n);
        check_value(u_model.log_addr[idx] == a && u_model.log_rd[idx] == rd
                    && u_model.log_num[idx] == n && (rd || u_model.log_wdata[idx] == wd),
                    $sformatf("transaction %0d is addr %h rd %b data %h num %0d", idx,
                              u_model.log_addr[idx], u_model.log_rd[idx],
                              u_model.log_wdata[idx], u_model.log_num[idx]));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt != errs_before)
            test_fail++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == errs_before) ? "ok" : "failed");
    endtask

    // one poll with the given status byte, results seen at the next poll
    task automatic touch_poll(input reg_data_t status);
        int        base;
        reg_data_t b [4*MAX_POINTS];
        logic [3:0] r;
        base = u_model.log_cnt - 1;     // status read just issued
        for (int k = 0; k < 4 * MAX_POINTS; k++) begin
            b[k] = $random(seed);
            u_model.regs[TP1_REG + TP_STRIDE * reg_addr_t'(k / 4) + reg_addr_t'(k % 4)] = b[k];
        end
        u_model.regs[STATUS_REG] = status;
        r         = decode_status(status);
        exp_valid = r[3];
        exp_num   = r[2:0];
        for (int i = 0; i < exp_num; i++)
            exp_slot[i] = pack_pair(b[4*i], b[4*i+1], b[4*i+2], b[4*i+3]);
        wait_log(base + 3 + exp_num, POLL_CYCLES + 4000, "the next status poll");
        compare_trans(base, STATUS_REG, 1'b1, 8'h00, 8'd1);
        compare_trans(base + 1, STATUS_REG, 1'b0, 8'h00, 8'd1);   // clear
        for (int i = 0; i < exp_num; i++)
            compare_trans(base + 2 + i, TP1_REG + TP_STRIDE * reg_addr_t'(i), 1'b1, 8'h00, 8'd4);
        compare_trans(base + 2 + exp_num, STATUS_REG, 1'b1, 8'h00, 8'd1);  // no extra reads
        check_value(tp_num == exp_num, $sformatf("tp_num %0d, expected %0d", tp_num, exp_num));
        check_value(touch_valid == exp_valid, $sformatf("touch_valid %b", touch_valid));
        for (int i = 0; i < MAX_POINTS; i++)
            check_value(slot_out(i) == exp_slot[i], $sformatf("slot %0d is %h, expected %h",
                        i, slot_out(i), exp_slot[i]));
    endtask

    initial begin
        int        n;
        int        errs;
        int        cnt1;
        int        cnt2;
        reg_data_t st;
        seed      = 32'h637c_db36;
        err_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;
        exp_num   = '0;
        exp_valid = 1'b0;
        for (int i = 0; i < MAX_POINTS; i++)
            exp_slot[i] = '0;

        // -------------------- power-up
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20)
                abort_run("reset release");
        end
        u_model.nack_next = 1'b1;   // first config write gets a nack
        errs = err_cnt;
        n = 0;
        while (tft_tcs !== 1'b1) begin
            @(negedge clk);
            n++;
            check_value(tft_int === 1'b1, "tft_int not driven high during panel reset");
            if (n > TCS_LOW_CYCLES + 10)
                abort_run("tft_tcs to rise");
        end
        check_value(n == TCS_LOW_CYCLES + 1, $sformatf("tft_tcs low for %0d cycles", n));
        n = 0;
        while (tft_int !== 1'bz) begin
            @(negedge clk);
            n++;
            check_value(tft_tcs === 1'b1, "tft_tcs fell after rising");
            check_value(tft_int === 1'b1 || tft_int === 1'bz, "tft_int not high before release");
            if (n > INT_RELEASE_CYCLES + 10)
                abort_run("tft_int release");
        end
        check_value(n == INT_RELEASE_CYCLES, $sformatf("tft_int released after %0d cycles", n));
        while (u_model.log_cnt == 0) begin
            @(negedge clk);
            n++;
            check_value(tft_tcs === 1'b1, "tft_tcs fell after rising");
            check_value(tft_int === 1'bz, "tft_int driven again after release");
            if (n > BOOT_WAIT_CYCLES + 100)
                abort_run("the first I2C request");
        end
        check_value(n > BOOT_WAIT_CYCLES, $sformatf("first request %0d cycles after tcs", n));
        finish_test("power-up", errs);

        // -------------------- configuration with one nack
        errs = err_cnt;
        wait_log(4, POLL_CYCLES + 2000, "the first status poll");
        compare_trans(0, CTRL_REG, 1'b0, CMD_SOFT_RESET, 8'd1);
        compare_trans(1, CTRL_REG, 1'b0, CMD_SOFT_RESET, 8'd1);   // retry
        compare_trans(2, CTRL_REG, 1'b0, CMD_READ_COORD, 8'd1);
        finish_test("configuration", errs);

        // -------------------- polls
        errs = err_cnt;
        st = $random(seed);
        cnt1 = 1 + ($unsigned($random(seed)) % 5);   // count nibble alone would be valid
        touch_poll((st & 8'h70) | reg_data_t'(cnt1));
        finish_test("no touch", errs);

        errs = err_cnt;
        cnt1 = 2 + ($unsigned($random(seed)) % 4);   // room for a smaller second touch
        st = $random(seed);
        touch_poll(8'h80 | (st & 8'h70) | reg_data_t'(cnt1));
        finish_test("random touch", errs);

        errs = err_cnt;
        cnt2 = 1 + ($unsigned($random(seed)) % (cnt1 - 1));
        touch_poll(8'h80 | reg_data_t'(cnt2));
        st = 8'h80 | reg_data_t'(6 + ($unsigned($random(seed)) % 10));
        touch_poll(st);
        finish_test("fewer points and invalid status", errs);

        $display("tests %0d, failed %0d, failed checks %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- tb/gt_touch_model.sv
// behavioral I2C byte engine with a GT9147 register image
// answers each request after a random delay and logs it

`timescale 1ns/1ps

module gt_touch_model #(
    parameter logic [31:0] SEED = 32'h637c_db36
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i2c_exec,
    input  logic                   i2c_rh_wl,
    input  gt_reg_pkg::reg_addr_t  i2c_addr,
    input  gt_reg_pkg::reg_data_t  i2c_data_w,
    input  gt_reg_pkg::burst_len_t reg_num,
    output logic                   ack,
    output logic                   i2c_done,
    output logic                   once_done,
    output gt_reg_pkg::reg_data_t  i2c_data_r
);
    import gt_reg_pkg::*;

    reg_data_t  regs [0:65535];     // chip register image
    integer     seed;
    logic       nack_next;          // nack the next transaction once

    // --------------------
    // transaction log
    int         log_cnt;
    reg_addr_t  log_addr  [0:255];
    logic       log_rd    [0:255];
    reg_data_t  log_wdata [0:255];
    burst_len_t log_num   [0:255];

    initial begin
        for (int a = 0; a < 65536; a++)
            regs[a] = a[15:8] ^ a[7:0] ^ 8'h5a;    // address-dependent fill
        seed       = SEED;
        nack_next  = 1'b0;
        log_cnt    = 0;
        ack        = 1'b0;
        i2c_done   = 1'b0;
        once_done  = 1'b0;
        i2c_data_r = '0;
    end

    always begin : engine
        reg_addr_t addr;
        logic      rd;
        reg_data_t wdata;
        int        num;
        logic      nk;
        @(posedge clk);
        if (rst_n && i2c_exec) begin
            addr  = i2c_addr;
            rd    = i2c_rh_wl;
            wdata = i2c_data_w;
            num   = reg_num;
            nk    = nack_next;
            nack_next = 1'b0;
            if (log_cnt < 256) begin
                log_addr[log_cnt]  = addr;
                log_rd[log_cnt]    = rd;
                log_wdata[log_cnt] = wdata;
                log_num[log_cnt]   = reg_num;
            end
            log_cnt++;
            // responses change on the falling edge
            for (int k = 0; k < num; k++) begin
                repeat (2 + ($random(seed) & 3)) @(negedge clk);   // bus time
                if (rd)
                    i2c_data_r = regs[reg_addr_t'(addr + k)];
                if (k == num - 1) begin
                    i2c_done = 1'b1;
                    ack      = nk;
                    if (!rd && !nk) begin
                        if (addr == STATUS_REG && wdata == 8'h00)
                            regs[addr][7] = 1'b0;  // buffer handed back
                        else
                            regs[addr] = wdata;
                    end
                end else begin
                    once_done = 1'b1;
                end
                @(negedge clk);
                i2c_done  = 1'b0;
                once_done = 1'b0;
                ack       = 1'b0;
            end
        end
    end

endmodule

//--- tb/tb_clk_gen.sv
// testbench clock and reset
// free-running clock, reset released on a falling edge

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

//--- verilog/touch_ctrl_top.sv
// GT9147 touch panel controller top
// power-up, polling sequencer, point assembly and result registers

`timescale 1ns/1ps

module touch_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   tft_tcs,
    inout  wire                    tft_int,
    input  logic                   ack,
    input  logic                   i2c_done,
    input  logic                   once_done,
    input  gt_reg_pkg::reg_data_t  i2c_data_r,
    output logic                   i2c_exec,
    output logic                   i2c_rh_wl,
    output gt_reg_pkg::reg_addr_t  i2c_addr,
    output gt_reg_pkg::reg_data_t  i2c_data_w,
    output gt_reg_pkg::burst_len_t reg_num,
    output gt_reg_pkg::tp_count_t  tp_num,
    output gt_reg_pkg::point_xy_t  tp1_xy,
    output gt_reg_pkg::point_xy_t  tp2_xy,
    output gt_reg_pkg::point_xy_t  tp3_xy,
    output gt_reg_pkg::point_xy_t  tp4_xy,
    output gt_reg_pkg::point_xy_t  tp5_xy,
    output logic                   touch_valid
);
    logic                  int_drive;
    logic                  int_level;
    logic                  boot_done;
    logic                  point_capture;
    logic                  point_wr;
    gt_reg_pkg::tp_count_t point_idx;
    gt_reg_pkg::point_xy_t point_xy;
    logic                  status_wr;
    gt_reg_pkg::tp_count_t status_count;
    logic                  status_valid;

    // INT is an output only during address select
    assign tft_int = int_drive ? int_level : 1'bz;

    tp_power_seq u_tp_power_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .tcs_out   (tft_tcs),
        .int_drive (int_drive),
        .int_level (int_level),
        .boot_done (boot_done)
    );

    touch_seq_fsm u_touch_seq_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .boot_done     (boot_done),
        .ack           (ack),
        .i2c_done      (i2c_done),
        .i2c_data_r    (i2c_data_r),
        .i2c_exec      (i2c_exec),
        .i2c_rh_wl     (i2c_rh_wl),
        .i2c_addr      (i2c_addr),
        .i2c_data_w    (i2c_data_w),
        .reg_num       (reg_num),
        .point_capture (point_capture),
        .point_wr      (point_wr),
        .point_idx     (point_idx),
        .status_wr     (status_wr),
        .status_count  (status_count),
        .status_valid  (status_valid)
    );

    tp_coord_assembler u_tp_coord_assembler (
        .clk           (clk),
        .rst_n         (rst_n),
        .point_capture (point_capture),
        .once_done     (once_done),
        .i2c_done      (i2c_done),
        .i2c_data_r    (i2c_data_r),
        .point_xy      (point_xy)
    );

    tp_coord_store u_tp_coord_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .point_wr     (point_wr),
        .point_idx    (point_idx),
        .point_xy     (point_xy),
        .status_wr    (status_wr),
        .status_count (status_count),
        .status_valid (status_valid),
        .tp_num       (tp_num),
        .touch_valid  (touch_valid),
        .tp1_xy       (tp1_xy),
        .tp2_xy       (tp2_xy),
        .tp3_xy       (tp3_xy),
        .tp4_xy       (tp4_xy),
        .tp5_xy       (tp5_xy)
    );

endmodule

//--- verilog/tp_coord_store.sv
// touch result registers
// point count, touch flag and five x/y slots

`timescale 1ns/1ps

module tp_coord_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  point_wr,
    input  gt_reg_pkg::tp_count_t point_idx,
    input  gt_reg_pkg::point_xy_t point_xy,
    input  logic                  status_wr,
    input  gt_reg_pkg::tp_count_t status_count,
    input  logic                  status_valid,
    output gt_reg_pkg::tp_count_t tp_num,
    output logic                  touch_valid,
    output gt_reg_pkg::point_xy_t tp1_xy,
    output gt_reg_pkg::point_xy_t tp2_xy,
    output gt_reg_pkg::point_xy_t tp3_xy,
    output gt_reg_pkg::point_xy_t tp4_xy,
    output gt_reg_pkg::point_xy_t tp5_xy
);
    import gt_reg_pkg::*;

    point_xy_t slot [MAX_POINTS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tp_num      <= '0;
            touch_valid <= 1'b0;
            for (int i = 0; i < MAX_POINTS; i++)
                slot[i] <= '0;
        end else begin
            if (status_wr) begin
                tp_num      <= status_count;
                touch_valid <= status_valid;
            end
            // slots above the new count keep their old value
            if (point_wr && (point_idx < MAX_POINTS))
                slot[point_idx] <= point_xy;
        end
    end

    assign tp1_xy = slot[0];
    assign tp2_xy = slot[1];
    assign tp3_xy = slot[2];
    assign tp4_xy = slot[3];
    assign tp5_xy = slot[4];

    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        point_wr |-> (point_idx < MAX_POINTS));

endmodule

//--- verilog/tp_coord_assembler.sv
// point burst assembler
// collects x lo, x hi, y lo, y hi from one 4-byte read

`timescale 1ns/1ps

module tp_coord_assembler (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  point_capture,
    input  logic                  once_done,
    input  logic                  i2c_done,
    input  gt_reg_pkg::reg_data_t i2c_data_r,
    output gt_reg_pkg::point_xy_t point_xy
);
    import gt_reg_pkg::*;

    logic       capture_d;
    logic [2:0] byte_cnt;
    logic [2:0] byte_sel;   // position of the byte arriving now
    logic       strobe;
    coord_t     tp_x;
    coord_t     tp_y;

    assign strobe   = point_capture && (once_done || i2c_done);
    assign byte_sel = (point_capture && !capture_d) ? 3'd0 : byte_cnt;
    assign point_xy = {tp_x, tp_y};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            capture_d <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            capture_d <= point_capture;
            byte_cnt  <= strobe ? byte_sel + 3'd1 : byte_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            case (byte_sel)
                3'd0: tp_x[7:0]  <= i2c_data_r;
                3'd1: tp_x[15:8] <= i2c_data_r;
                3'd2: tp_y[7:0]  <= i2c_data_r;
                3'd3: tp_y[15:8] <= i2c_data_r;
                default: ;
            endcase
        end
    end

    // engine must not deliver more than one point per burst
    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        strobe |-> (byte_sel < POINT_BYTES));

endmodule

//--- verilog/touch_seq_fsm.sv
// main touch sequencer
// control writes, periodic status polling, status clear and point reads,
// every transaction reissued on nack

`timescale 1ns/1ps

module touch_seq_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   boot_done,
    input  logic                   ack,
    input  logic                   i2c_done,
    input  gt_reg_pkg::reg_data_t  i2c_data_r,
    output logic                   i2c_exec,
    output logic                   i2c_rh_wl,
    output gt_reg_pkg::reg_addr_t  i2c_addr,
    output gt_reg_pkg::reg_data_t  i2c_data_w,
    output gt_reg_pkg::burst_len_t reg_num,
    output logic                   point_capture,
    output logic                   point_wr,
    output gt_reg_pkg::tp_count_t  point_idx,
    output logic                   status_wr,
    output gt_reg_pkg::tp_count_t  status_count,
    output logic                   status_valid
);
    import gt_reg_pkg::*;
    import touch_ctrl_pkg::*;

    touch_state_e state;
    logic         step;         // 0 issue, 1 wait for i2c_done
    delay_cnt_t   poll_timer;
    tp_count_t    point_cnt;    // points to fetch in this poll
    logic         touch_ok;
    tp_count_t    touch_cnt;
    reg_addr_t    point_addr;

    // --------------------
    // status byte decode
    assign touch_ok = i2c_data_r[7] && (i2c_data_r[3:0] != 4'd0)
                      && (i2c_data_r[3:0] <= MAX_POINTS);
    assign touch_cnt = touch_ok ? i2c_data_r[2:0] : '0;

    assign point_addr = TP1_REG + reg_addr_t'(point_idx) * TP_STRIDE;

    // --------------------
    // sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= wait_boot;
            step          <= 1'b0;
            poll_timer    <= '0;
            point_cnt     <= '0;
            point_idx     <= '0;
            i2c_exec      <= 1'b0;
            i2c_rh_wl     <= 1'b0;
            i2c_addr      <= '0;
            i2c_data_w    <= '0;
            reg_num       <= '0;
            point_capture <= 1'b0;
            point_wr      <= 1'b0;
            status_wr     <= 1'b0;
            status_count  <= '0;
            status_valid  <= 1'b0;
        end else begin
            i2c_exec  <= 1'b0;
            point_wr  <= 1'b0;
            status_wr <= 1'b0;
            case (state)
                wait_boot: begin
                    if (boot_done)
                        state <= cfg_reset;
                end
                cfg_reset: begin
                    if (!step) begin
                        i2c_exec   <= 1'b1;
                        i2c_rh_wl  <= 1'b0;
                        i2c_addr   <= CTRL_REG;
                        i2c_data_w <= CMD_SOFT_RESET;
                        reg_num    <= 8'd1;
                        step       <= 1'b1;
                    end else if (i2c_done) begin
                        step <= 1'b0;           // nack retries from step 0
                        if (!ack)
                            state <= cfg_run;
                    end
                end
                cfg_run: begin
                    if (!step) begin
                        i2c_exec   <= 1'b1;
                        i2c_rh_wl  <= 1'b0;
                        i2c_addr   <= CTRL_REG;
                        i2c_data_w <= CMD_READ_COORD;
                        reg_num    <= 8'd1;
                        step       <= 1'b1;
                    end else if (i2c_done) begin
                        step <= 1'b0;
                        if (!ack)
                            state <= poll_wait;
                    end
                end
                poll_wait: begin
                    if (poll_timer == POLL_CYCLES - 1) begin
                        poll_timer <= '0;
                        state      <= status_read;
                    end else begin
                        poll_timer <= poll_timer + 1'b1;
                    end
                end
                status_read: begin
                    if (!step) begin
                        i2c_exec  <= 1'b1;
                        i2c_rh_wl <= 1'b1;
                        i2c_addr  <= STATUS_REG;
                        reg_num   <= 8'd1;
                        step      <= 1'b1;
                    end else if (i2c_done) begin
                        step <= 1'b0;
                        if (!ack) begin
                            status_wr    <= 1'b1;
                            status_count <= touch_cnt;
                            status_valid <= touch_ok;
                            point_cnt    <= touch_cnt;
                            state        <= status_clear;
                        end
                    end
                end
                status_clear: begin
                    if (!step) begin
                        i2c_exec   <= 1'b1;
                        i2c_rh_wl  <= 1'b0;
                        i2c_addr   <= STATUS_REG;
                        i2c_data_w <= 8'h00;    // hands the buffer back to the chip
                        reg_num    <= 8'd1;
                        step       <= 1'b1;
                    end else if (i2c_done) begin
                        step <= 1'b0;
                        if (!ack) begin
                            point_idx <= '0;
                            state     <= (point_cnt != '0) ? point_read : poll_wait;
                        end
                    end
                end
                point_read: begin
                    if (!step) begin
                        i2c_exec      <= 1'b1;
                        i2c_rh_wl     <= 1'b1;
                        i2c_addr      <= point_addr;
                        reg_num       <= burst_len_t'(POINT_BYTES);
                        point_capture <= 1'b1;
                        step          <= 1'b1;
                    end else if (i2c_done) begin
                        point_capture <= 1'b0;  // low gap restarts the byte count
                        step          <= 1'b0;
                        if (!ack)
                            state <= point_store;
                    end
                end
                point_store: begin
                    // point_idx must hold while point_wr is high
                    if (!step) begin
                        point_wr <= 1'b1;
                        step     <= 1'b1;
                    end else begin
                        step <= 1'b0;
                        if (point_idx == point_cnt - 1'b1) begin
                            state <= poll_wait;
                        end else begin
                            point_idx <= point_idx + 1'b1;
                            state     <= point_read;
                        end
                    end
                end
                default: state <= wait_boot;
            endcase
        end
    end

    // --------------------
    // engine handshake
    a_exec_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i2c_exec |=> !i2c_exec);

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        i2c_exec |=> (!i2c_exec until_with i2c_done));

endmodule

//--- verilog/tp_power_seq.sv
// panel power-up sequence
// holds reset low with INT driven high to select the I2C address,
// then releases reset, later INT, and flags boot_done once

`timescale 1ns/1ps

module tp_power_seq (
    input  logic clk,
    input  logic rst_n,
    output logic tcs_out,
    output logic int_drive,
    output logic int_level,
    output logic boot_done
);
    import touch_ctrl_pkg::*;

    typedef enum logic [1:0] {
        ph_hold,    // panel held in reset
        ph_boot,    // reset released, firmware starting
        ph_idle
    } phase_e;

    phase_e     phase;
    delay_cnt_t cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= ph_hold;
            cnt       <= '0;
            tcs_out   <= 1'b0;
            int_drive <= 1'b0;
            int_level <= 1'b0;
            boot_done <= 1'b0;
        end else begin
            boot_done <= 1'b0;
            case (phase)
                ph_hold: begin
                    int_drive <= 1'b1;      // INT high while reset low
                    int_level <= 1'b1;
                    if (cnt == TCS_LOW_CYCLES) begin
                        tcs_out <= 1'b1;
                        cnt     <= '0;
                        phase   <= ph_boot;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ph_boot: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == INT_RELEASE_CYCLES - 1)
                        int_drive <= 1'b0;  // address latched, pin back to input
                    if (cnt == BOOT_WAIT_CYCLES - 1) begin
                        boot_done <= 1'b1;
                        cnt       <= '0;
                        phase     <= ph_idle;
                    end
                end
                ph_idle: ;
                default: phase <= ph_idle;
            endcase
        end
    end

    // panel must not be put back into reset once running
    a_tcs_stays_high: assert property (@(posedge clk) disable iff (!rst_n)
        tcs_out |=> tcs_out);

endmodule

//--- verilog/touch_ctrl_pkg.sv
// touch controller timing and sequencer states
// counts are in clk cycles

package touch_ctrl_pkg;

    // --------------------
    // timing
    typedef logic [19:0] delay_cnt_t;

    localparam delay_cnt_t TCS_LOW_CYCLES     = 20'd20000;   // panel reset low time
    localparam delay_cnt_t INT_RELEASE_CYCLES = 20'd10000;   // after tcs rises
    localparam delay_cnt_t BOOT_WAIT_CYCLES   = 20'd100000;  // firmware boot time
    localparam delay_cnt_t POLL_CYCLES        = 20'd17000;   // status poll interval

    // --------------------
    // main sequencer states
    typedef enum logic [2:0] {
        wait_boot,      // power-up still running
        cfg_reset,      // soft reset command
        cfg_run,        // back to coordinate read mode
        poll_wait,
        status_read,
        status_clear,   // write 0 back to the status register
        point_read,     // 4-byte burst per point
        point_store
    } touch_state_e;

endpackage

//--- verilog/gt_reg_pkg.sv
// GT9147 touch chip register map
// command values and the data widths seen on the I2C side

package gt_reg_pkg;

    // --------------------
    // data widths
    typedef logic [15:0] reg_addr_t;    // 16-bit register address
    typedef logic [7:0]  reg_data_t;
    typedef logic [15:0] coord_t;

    // x in the upper half, y in the lower half
    typedef logic [2*$bits(coord_t)-1:0] point_xy_t;

    typedef logic [2:0]  tp_count_t;    // point count or slot index
    typedef logic [7:0]  burst_len_t;   // registers per transaction

    // --------------------
    // register map
    localparam reg_addr_t CTRL_REG   = 16'h8040;   // command register
    localparam reg_addr_t STATUS_REG = 16'h814E;   // touch status, bit 7 = buffer ready
    localparam reg_addr_t TP1_REG    = 16'h8150;   // first point data
    localparam reg_addr_t TP_STRIDE  = 16'd8;      // address step between points

    // --------------------
    // command values
    localparam reg_data_t CMD_SOFT_RESET = 8'h02;
    localparam reg_data_t CMD_READ_COORD = 8'h00;

    // point layout
    localparam int MAX_POINTS  = 5;
    localparam int POINT_BYTES = 4;     // x lo, x hi, y lo, y hi

endpackage
